//--- Makefile
# Verilator flow for the 8x8 Life engine testbench

BIN = obj_dir/Vconway_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary -f conway_8x8_serial.f --top-module conway_tb

run: compile
	-./$(BIN) > sim.log 2>&1
	@cat sim.log
	@grep -q "TEST RESULT: PASS" sim.log && echo "simulation passed" || \
		(echo "simulation failed"; exit 1)

clean:
	rm -rf obj_dir sim.log

//--- conway_8x8_serial.f
design/life_grid_pkg.sv
design/life_mode_pkg.sv
design/life_cell.sv
design/cell_grid.sv
design/life_memory.sv
design/serial_out_shift.sv
design/conway_8x8_serial.sv
testbench/conway_tb.sv

//--- design/cell_grid.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Zero-latency next-generation logic. Edges are dead, no wrap-around
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module cell_grid
    import life_grid_pkg::*;
(
    input  grid_word_t mem_state,  // Current board
    output grid_word_t next_state  // Board one generation on
);

    // Board with a one-cell ring of dead cells around it
    // Board cell (r,c) sits at padded[r+1][c+1]
    logic [grid_height+1:0][grid_width+1:0] padded;

    always_comb begin
        padded = '0;                                          // Border stays dead
        for (int r = 0; r < grid_height; r++) begin
            for (int c = 0; c < grid_width; c++) begin
                padded[r+1][c+1] = mem_state.rows[r][c];
            end
        end
    end

    // One rule cell per board position
    for (genvar r = 0; r < grid_height; r++) begin : g_row
        for (genvar c = 0; c < grid_width; c++) begin : g_col
            logic [7:0] nbrs; // Ring around (r,c), taken from padded coords

            assign nbrs = {
                padded[r+2][c+2],   // Row above, column right
                padded[r+2][c+1],   // Row above
                padded[r+2][c],     // Row above, column left
                padded[r+1][c+2],   // Same row, right
                padded[r+1][c],     // Same row, left
                padded[r][c+2],     // Row below, right
                padded[r][c+1],     // Row below
                padded[r][c]        // Row below, left
            };

            life_cell cell0 (
                .alive      (mem_state.rows[r][c]),
                .neighbours (nbrs),
                .next_alive (next_state.rows[r][c])
            );
        end
    end

endmodule

`default_nettype wire

//--- design/conway_8x8_serial.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 8x8 Life on serial pins. No handshake, the controller paces
// everything through mode. LEDs are plain combinational mirrors
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module conway_8x8_serial
    import life_grid_pkg::*;
    import life_mode_pkg::*;
(
    input  logic                 clk,       // System clock
    input  logic                 reset,     // Sync reset, active high
    input  logic                 data_in,   // Serial cell input
    input  logic [mode_bits-1:0] mode,      // 00 load, 01 run, 10 output, 11 stop
    output logic                 data_out,  // Serial cell output
    output logic                 din_led,   // Debug copy of data_in
    output logic                 dout_led,  // Debug copy of data_out
    output logic [mode_bits-1:0] mode_leds  // Debug copy of mode
);

    grid_word_t mem_state;  // Stored board
    grid_word_t next_state; // Next generation, combinational
    logic       serial_out; // Shifter output, also feeds the LED

    // Board storage, also the input shift register
    life_memory memory0 (
        .clk        (clk),
        .reset      (reset),
        .mode       (mode),
        .data_in    (data_in),
        .next_state (next_state),
        .mem_state  (mem_state)
    );

    // Rule evaluation for all 64 cells at once
    cell_grid grid0 (
        .mem_state  (mem_state),
        .next_state (next_state)
    );

    // Parallel to serial on the way out
    serial_out_shift shift0 (
        .clk        (clk),
        .reset      (reset),
        .mode       (mode),
        .next_state (next_state),
        .data_out   (serial_out)
    );

    assign data_out = serial_out;

    // Debug mirrors
    assign din_led   = data_in;
    assign dout_led  = serial_out;
    assign mode_leds = mode;

endmodule

`default_nettype wire

//--- design/life_cell.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pure combinational rule, B3/S23. Off-board neighbours come in as 0
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module life_cell (
    input  logic       alive,      // Current state of this cell
    input  logic [7:0] neighbours, // Eight surrounding cells, any order
    output logic       next_alive  // State in the next generation
);

    logic [3:0] live_count; // 0..8 live neighbours
    logic       born;       // Dead cell with exactly three
    logic       survives;   // Live cell with two or three

    // Population count of the neighbour ring
    always_comb begin
        live_count = '0;
        for (int i = 0; i < 8; i++) begin
            live_count = live_count + {3'b000, neighbours[i]};
        end
    end

    assign born     = !alive && (live_count == 4'd3);
    assign survives = alive && ((live_count == 4'd2) || (live_count == 4'd3));

    // Everything else dies or stays dead
    assign next_alive = born || survives;

endmodule

`default_nettype wire

//--- design/life_grid_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Board geometry is fixed at 8x8. Cell (r,c) is flat bit r*8+c
// Row 7 sits in the top byte of the word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package life_grid_pkg;

    localparam int grid_width  = 8;                       // Cells per row
    localparam int grid_height = 8;                       // Rows on the board
    localparam int grid_cells  = grid_width * grid_height; // Total cells, 64

    // One board word seen two ways
    // flat  is for the serial shift paths
    // rows  is for neighbour lookup in the grid
    // rows[r][c] and flat[r*grid_width+c] name the same bit
    typedef union packed {
        logic [grid_cells-1:0]                   flat; // Whole board as one vector
        logic [grid_height-1:0][grid_width-1:0]  rows; // Row-major view, row 7 at the MSBs
    } grid_word_t;

endpackage

`default_nettype wire

//--- design/life_memory.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 64 load clocks put the first bit sent in bit 63 (row 7, col 7)
// Board holds in output and stop modes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module life_memory
    import life_grid_pkg::*;
    import life_mode_pkg::*;
(
    input  logic                 clk,        // System clock
    input  logic                 reset,      // Sync reset, active high
    input  logic [mode_bits-1:0] mode,       // System mode
    input  logic                 data_in,    // Serial cell input
    input  grid_word_t           next_state, // Next generation from the grid
    output grid_word_t           mem_state   // Current board
);

    logic load_mode; // Shift serial data into the board
    logic run_mode;  // Advance one generation

    assign load_mode = (mode == mode_load);
    assign run_mode  = (mode == mode_run);

    // Input shifter and state register share one word
    always_ff @(posedge clk) begin
        if (reset) begin
            mem_state.flat <= '0;                                         // Empty board
        end else if (load_mode) begin
            mem_state.flat <= {mem_state.flat[grid_cells-2:0], data_in};  // New cell in at bit 0
        end else if (run_mode) begin
            mem_state <= next_state;                                      // Take next generation
        end
        // Output and stop fall through and keep the board
    end

endmodule

`default_nettype wire

//--- design/life_mode_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Mode codes driven by the external controller on the mode pins
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package life_mode_pkg;

    localparam int mode_bits = 2; // Width of the mode bus

    localparam logic [mode_bits-1:0] mode_load   = 2'b00; // Shift board in
    localparam logic [mode_bits-1:0] mode_run    = 2'b01; // One generation per clock
    localparam logic [mode_bits-1:0] mode_output = 2'b10; // Shift board out
    localparam logic [mode_bits-1:0] mode_stop   = 2'b11; // Hold everything

endpackage

`default_nettype wire

//--- design/serial_out_shift.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MSB-first serialiser. Tracks the grid output in load and run,
// so the first cell is on data_out when output mode starts
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module serial_out_shift
    import life_grid_pkg::*;
    import life_mode_pkg::*;
(
    input  logic                 clk,        // System clock
    input  logic                 reset,      // Sync reset, active high
    input  logic [mode_bits-1:0] mode,       // System mode
    input  grid_word_t           next_state, // Board to capture
    output logic                 data_out    // Serial cell output
);

    logic [grid_cells-1:0] shift_q; // Capture and shift register

    always_ff @(posedge clk) begin
        if (reset) begin
            shift_q <= '0;                                       // data_out low after reset
        end else begin
            case (mode)
                mode_load, mode_run: shift_q <= next_state.flat; // Parallel capture
                mode_output: shift_q <= {shift_q[grid_cells-2:0], 1'b0}; // Zero fill from below
                default: shift_q <= shift_q;                     // Stop holds position
            endcase
        end
    end

    // Top bit is the next cell on the pin
    assign data_out = shift_q[grid_cells-1];

endmodule

`default_nettype wire

//--- testbench/conway_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Board is read back through data_out only. Every entry runs at least
// one generation, so the shifter holds the final board at read-back
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module conway_tb
    import life_grid_pkg::*;
    import life_mode_pkg::*;
();

    localparam int num_entries = 9;               // Rows in the stimulus table
    localparam int out_limit   = grid_cells + 16; // Cycle budget for one read-back
    localparam int stop_cycles = 5;               // Stop cycles between run and output

    logic                 clk;
    logic                 reset;
    logic                 data_in;
    logic [mode_bits-1:0] mode;
    logic                 data_out;
    logic                 din_led;
    logic                 dout_led;
    logic [mode_bits-1:0] mode_leds;

    // Stimulus table with expected boards from the model at run time
    grid_word_t start_board [num_entries]; // Board shifted in
    int         gen_count   [num_entries]; // At least one run cycle per entry
    string      entry_name  [num_entries];
    bit         hold_before [num_entries]; // Park in stop before output
    bit         hold_midway [num_entries]; // Suspend output halfway

    logic [31:0]          lfsr_state;   // Random source for the LFSR boards
    logic [mode_bits-1:0] applied_mode; // Mode the DUT acted on at the last edge
    string                cur_name;     // Entry under test, for error lines

    conway_8x8_serial dut0 (
        .clk       (clk),
        .reset     (reset),
        .data_in   (data_in),
        .mode      (mode),
        .data_out  (data_out),
        .din_led   (din_led),
        .dout_led  (dout_led),
        .mode_leds (mode_leds)
    );

    always #5 clk = ~clk; // 10 ns period

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_bit(input logic expected, input logic actual, input string what);
        if (actual !== expected) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s: %s expected %b, got %b",
                                $time, cur_name, what, expected, actual));
        end
    endtask

    task automatic check_grid(input grid_word_t expected, input grid_word_t actual,
                              input string what);
        if (actual.flat !== expected.flat) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s: %s expected %h, got %h",
                                $time, cur_name, what, expected.flat, actual.flat));
        end
    endtask

    // Right-shifting Galois LFSR with taps x^32+x^31+x^29+x+1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'hD000_0001;
        end
        return n;
    endfunction

    // One LFSR step per cell taken
    task automatic draw_board(output grid_word_t b);
        for (int i = 0; i < grid_cells; i++) begin
            b.flat[i] = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // Reference step with the B3/S23 rule and a dead border
    function automatic grid_word_t life_step(input grid_word_t cur);
        grid_word_t nxt;
        int         count;
        int         rr;
        int         cc;
        nxt.flat = '0;
        for (int r = 0; r < grid_height; r++) begin
            for (int c = 0; c < grid_width; c++) begin
                count = 0;
                for (int dr = -1; dr <= 1; dr++) begin
                    for (int dc = -1; dc <= 1; dc++) begin
                        rr = r + dr;
                        cc = c + dc;
                        if ((dr != 0 || dc != 0) && rr >= 0 && rr < grid_height
                            && cc >= 0 && cc < grid_width) begin
                            if (cur.flat[rr*grid_width + cc]) begin
                                count++;
                            end
                        end
                    end
                end
                if (cur.flat[r*grid_width + c]) begin
                    nxt.flat[r*grid_width + c] = (count == 2 || count == 3); // Survival
                end else begin
                    nxt.flat[r*grid_width + c] = (count == 3);               // Birth
                end
            end
        end
        return nxt;
    endfunction

    // Drive on the rising edge and sample at the falling edge
    task automatic clock_cycle(input logic [mode_bits-1:0] m, input logic d);
        @(posedge clk);
        applied_mode = mode;   // Old value that the DUT just acted on
        mode    <= m;
        data_in <= d;
        @(negedge clk);
        check_bit(data_in, din_led, "din_led mirror");
        check_bit(data_out, dout_led, "dout_led mirror");
        check_bit(mode[0], mode_leds[0], "mode_leds[0] mirror");
        check_bit(mode[1], mode_leds[1], "mode_leds[1] mirror");
    endtask

    // Collect 64 cells into bits 63 down to 0 with an optional stop halfway
    task automatic read_back(input logic midway, input grid_word_t want,
                             output grid_word_t got);
        int shifts; // Output-mode edges seen by the DUT
        int holds;  // Stop cycles driven so far
        int cycles;
        shifts   = 0;
        holds    = 0;
        cycles   = 0;
        got.flat = '0;
        while (shifts < grid_cells) begin
            if (cycles >= out_limit) begin
                abort_run($sformatf("Timeout: read-back of %s did not finish in %0d cycles",
                                    cur_name, out_limit));
            end
            if (midway && shifts >= grid_cells / 2 && holds < 4) begin
                clock_cycle(mode_stop, 1'b0);
                holds++;
            end else begin
                clock_cycle(mode_output, 1'b0);
            end
            cycles++;
            if (applied_mode == mode_output) begin
                shifts++;
            end
            if (shifts < grid_cells) begin
                if (applied_mode == mode_stop) begin
                    check_bit(want.flat[grid_cells-1-shifts], data_out,
                              "data_out held in stop");
                end
                got.flat[grid_cells-1-shifts] = data_out;
            end else begin
                check_bit(1'b0, data_out, "data_out after last cell"); // Zero fill
            end
        end
    endtask

    task automatic set_entry(input int k, input grid_word_t b, input int gens,
                             input string name, input bit hb, input bit hm);
        start_board[k] = b;
        gen_count[k]   = gens;
        entry_name[k]  = name;
        hold_before[k] = hb;
        hold_midway[k] = hm;
    endtask

    task automatic build_table();
        grid_word_t b;
        set_entry(0, 64'h0000_0000_0000_0000, 1, "empty", 1'b0, 1'b0);
        set_entry(1, 64'h0000_0018_1800_0000, 3, "block", 1'b1, 1'b0);   // Still life
        set_entry(2, 64'h0000_0000_1C00_0000, 3, "blinker", 1'b0, 1'b0); // Period 2
        set_entry(3, 64'h0000_0000_0007_0402, 4, "glider", 1'b0, 1'b1);  // Moves one diagonal
        set_entry(4, 64'hFFFF_FFFF_FFFF_FFFF, 1, "full", 1'b0, 1'b0);    // Edges see dead ring
        set_entry(5, 64'h8100_0000_0000_0081, 1, "corners", 1'b1, 1'b1);
        draw_board(b);
        set_entry(6, b, 1, "random_0", 1'b0, 1'b0);
        draw_board(b);
        set_entry(7, b, 2, "random_1", 1'b0, 1'b1);
        draw_board(b);
        set_entry(8, b, 5, "random_2", 1'b1, 1'b1);
    endtask

    // Load MSB first then run, park, read back and compare
    task automatic run_entry(input int k);
        grid_word_t expected;
        grid_word_t got;
        cur_name = entry_name[k];
        expected = start_board[k];
        for (int g = 0; g < gen_count[k]; g++) begin
            expected = life_step(expected);
        end
        for (int i = grid_cells - 1; i >= 0; i--) begin
            clock_cycle(mode_load, start_board[k].flat[i]);
        end
        for (int g = 0; g < gen_count[k]; g++) begin
            clock_cycle(mode_run, 1'b0);
        end
        if (hold_before[k]) begin
            for (int s = 0; s < stop_cycles; s++) begin
                clock_cycle(mode_stop, 1'b0); // First edge here takes the last run
                check_bit(expected.flat[grid_cells-1], data_out, "data_out in stop");
            end
        end
        read_back(hold_midway[k], expected, got);
        check_grid(expected, got, "board read back");
        // Memory kept its board through stop and output, so one more run steps from it
        expected = life_step(expected);
        clock_cycle(mode_run, 1'b0);
        read_back(1'b0, expected, got);
        check_grid(expected, got, "board after one more run");
    endtask

    initial begin
        grid_word_t got;
        grid_word_t blank;
        clk        = 1'b0;
        reset      = 1'b1;
        data_in    = 1'b0;
        mode       = mode_stop;
        lfsr_state = 32'h8a06_752f;
        cur_name   = "reset";
        blank.flat = '0;
        build_table();
        for (int i = 0; i < 2; i++) begin
            @(posedge clk);             // Two reset edges
        end
        reset <= 1'b0;
        @(negedge clk);
        check_bit(1'b0, data_out, "data_out after reset");
        read_back(1'b0, blank, got);    // Nothing loaded yet
        check_grid(blank, got, "read-back after reset");
        for (int k = 0; k < num_entries; k++) begin
            run_entry(k);
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire
